// File: build.f
+incdir+common
common/lane_pkg.sv
design/lane_cmd_dispatch.sv
operand_requester/operand_requester.sv
vrf/vrf_banks.sv
design/lane_top.sv
verification/tb_lane.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the lane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_lane -f build.f -o tb_lane
./obj_dir/tb_lane | tee sim.log

if grep -q 'All tests passed!' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: verification/tb_lane.sv
////////////////////////////////////////
// Random lane testbench with a VRF model
// and per-queue expected operand streams
////////////////////////////////////////
`timescale 1ns/1ns
`include "lane_config.svh"

module tb_lane import lane_pkg::*; ();

  localparam int nr_queues  = `LANE_NR_QUEUES;
  localparam int wait_limit = 2000;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic                  wb_adr;
  logic [31:0]           wb_wdat;
  logic [31:0]           wb_rdat;
  logic                  wb_ack;
  logic [nr_queues-1:0]  opq_ready;
  logic [nr_queues-1:0]  opq_valid;
  elem_t [nr_queues-1:0] opq_data;

  integer seed      = 32'h7462_da80;
  int     errors    = 0;
  int     wr_acks   = 0;
  int     delivered = 0;
  int     haz_queue = -1;
  int     haz_base  = 0;
  int     haz_seen  = 0;
  logic   bp_mode   = 1'b0;
  elem_t  vrf_model [256];
  elem_t  exp_q [nr_queues][$];

  lane_top uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_wdat),
    .wb_dat_o    (wb_rdat),
    .wb_ack_o    (wb_ack),
    .opq_ready_i (opq_ready),
    .opq_valid_o (opq_valid),
    .opq_data_o  (opq_data)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("Errors: %0d", errors + 1);
    $display("Test failures found");
    $finish;
  endtask

  // Ack is a registered pulse, sampled on the falling edge
  task automatic wait_ack();
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while (!wb_ack && cnt < wait_limit) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!wb_ack) begin
      stop_on_timeout("a Wishbone ack");
    end
  endtask

  task automatic wb_write(input logic adr, input logic [31:0] data);
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = 1'b1;
    wb_adr  = adr;
    wb_wdat = data;
    wait_ack();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic adr, output logic [31:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack();
    data   = wb_rdat;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic write_elem(input vaddr_t addr, input elem_t data);
    lane_cmd_u cmd;
    cmd         = '0;
    cmd.wr.kind = 1'b1;
    cmd.wr.addr = addr;
    cmd.wr.data = data;
    wb_write(1'b0, cmd);
    vrf_model[addr] = data;
    wr_acks++;
  endtask

  // Expected elements follow the start address and wrap over the VRF
  task automatic read_operand(input int q, input int vreg, input int vstart,
                              input int vl, input logic hazard);
    lane_cmd_u cmd;
    vaddr_t    start;
    cmd           = '0;
    cmd.rd.queue  = 2'(q);
    cmd.rd.vreg   = 5'(vreg);
    cmd.rd.vstart = 3'(vstart);
    cmd.rd.vl     = 4'(vl);
    cmd.rd.hazard = hazard;
    wb_write(1'b0, cmd);
    start = 8'(vreg * `LANE_VREG_ELEMS + vstart);
    for (int i = 0; i < vl; i++) begin
      exp_q[q].push_back(vrf_model[8'(start + i)]);
    end
    if (hazard) begin
      haz_queue = q;
      haz_base  = wr_acks;
      haz_seen  = 0;
    end
  endtask

  // Poll the busy mask until every requester is idle
  task automatic wait_idle();
    logic [31:0] status;
    int          cnt;
    cnt = 0;
    wb_read(1'b1, status);
    while (status[nr_queues-1:0] != '0 && cnt < wait_limit) begin
      wb_read(1'b1, status);
      cnt++;
    end
    if (status[nr_queues-1:0] != '0) begin
      stop_on_timeout("idle requesters");
    end else begin
      @(negedge clk_i);
      for (int q = 0; q < nr_queues; q++) begin
        check_value("stream length", 0, 32'(exp_q[q].size()));
      end
    end
  endtask

  // Output monitor, then the next ready value for each queue
  always @(negedge clk_i) begin
    logic [31:0] r;
    for (int q = 0; q < nr_queues; q++) begin
      if (rst_ni && opq_valid[q]) begin
        delivered++;
        if (!opq_ready[q]) begin
          errors++;
          $display("Queue %0d delivered an element after a cycle without ready", q);
        end
        if (exp_q[q].size() == 0) begin
          errors++;
          $display("Queue %0d delivered an element that was never requested", q);
        end else begin
          check_value("operand element", 32'(exp_q[q].pop_front()), 32'(opq_data[q]));
        end
        if (q == haz_queue) begin
          haz_seen++;
          if (haz_seen > wr_acks - haz_base) begin
            errors++;
            $display("Hazard read on queue %0d ran ahead of the result writes", q);
          end
        end
      end
      r = rand_word();
      opq_ready[q] = bp_mode ? (r[1:0] != 2'b00) : 1'b1;
    end
  end

  initial begin
    logic [31:0] status;
    int          vreg;
    int          vl;
    int          count;
    vaddr_t      addr;
    rst_ni    = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = 1'b0;
    wb_wdat   = '0;
    opq_ready = '1;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    // Quiet lane after reset
    repeat (20) @(negedge clk_i);
    check_value("no output after reset", 0, 32'(delivered));

    // Fill every element, then read back each register
    for (int a = 0; a < 256; a++) begin
      write_elem(8'(a), 16'(rand_word()));
    end
    for (int r = 0; r < 32; r++) begin
      read_operand(int'(rand_word() % 32'd3), r, 0, `LANE_VREG_ELEMS, 1'b0);
    end
    wait_idle();

    // Three queues at once on neighbouring registers
    vreg = int'(rand_word() % 32'd30);
    for (int q = 0; q < nr_queues; q++) begin
      read_operand(q, vreg + q, int'(rand_word() % 32'd8),
                   1 + int'(rand_word() % 32'd15), 1'b0);
    end
    wait_idle();

    // Random back-pressure on all queues
    bp_mode = 1'b1;
    for (int n = 0; n < 12; n++) begin
      read_operand(n % nr_queues, int'(rand_word() % 32'd32),
                   int'(rand_word() % 32'd8), 1 + int'(rand_word() % 32'd15), 1'b0);
    end
    wait_idle();
    bp_mode = 1'b0;

    // Hazard read paced by slow writes outside its register
    vreg = int'(rand_word() % 32'd32);
    vl   = 1 + int'(rand_word() % 32'd8);
    read_operand(0, vreg, 0, vl, 1'b1);
    for (int n = 0; n < vl + 2; n++) begin
      repeat (1 + int'(rand_word() % 32'd6)) @(negedge clk_i);
      addr = 8'(rand_word());
      if (addr[7:3] == 5'(vreg)) begin
        addr[7] = ~addr[7];
      end
      write_elem(addr, 16'(rand_word()));
    end
    wait_idle();
    check_value("hazard stream length", 32'(vl), 32'(haz_seen));
    haz_queue = -1;

    // Busy bit follows a command, empty command stays idle
    read_operand(1, vreg, 0, `LANE_VREG_ELEMS, 1'b0);
    wb_read(1'b1, status);
    check_value("busy after command", 1, 32'(status[1]));
    wait_idle();
    count = delivered;
    read_operand(2, vreg, 0, 0, 1'b0);
    wb_read(1'b1, status);
    check_value("busy after empty command", 0, 32'(status[2]));
    repeat (20) @(negedge clk_i);
    check_value("empty operand output", 32'(count), 32'(delivered));

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: design/lane_top.sv
////////////////////////////////////////
// Lane top: dispatcher, requesters, VRF
////////////////////////////////////////
`timescale 1ns/1ns
`include "lane_config.svh"

module lane_top import lane_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Wishbone classic slave
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic                          wb_adr_i,
  input  logic  [31:0]                  wb_dat_i,
  output logic  [31:0]                  wb_dat_o,
  output logic                          wb_ack_o,
  // Operand queue streams
  input  logic  [`LANE_NR_QUEUES-1:0]   opq_ready_i,
  output logic  [`LANE_NR_QUEUES-1:0]   opq_valid_o,
  output elem_t [`LANE_NR_QUEUES-1:0]   opq_data_o
);

  localparam int unsigned nr_queues = `LANE_NR_QUEUES;

  logic   [nr_queues-1:0] req_valid;
  logic   [nr_queues-1:0] req_ready;
  vaddr_t [nr_queues-1:0] req_addr;
  vlen_t  [nr_queues-1:0] req_len;
  logic   [nr_queues-1:0] req_hazard;
  logic                   wr_req;
  vaddr_t                 wr_addr;
  elem_t                  wr_data;
  logic                   wr_gnt;
  logic                   result_written;
  logic   [nr_queues-1:0] rd_req;
  vaddr_t [nr_queues-1:0] rd_addr;
  logic   [nr_queues-1:0] rd_gnt;

  lane_cmd_dispatch u_dispatch (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .req_valid_o  (req_valid),
    .req_ready_i  (req_ready),
    .req_addr_o   (req_addr),
    .req_len_o    (req_len),
    .req_hazard_o (req_hazard),
    .wr_req_o     (wr_req),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .wr_gnt_i     (wr_gnt)
  );

  for (genvar q = 0; q < nr_queues; q++) begin : gen_requester
    operand_requester u_requester (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .cmd_valid_i      (req_valid[q]),
      .cmd_ready_o      (req_ready[q]),
      .cmd_addr_i       (req_addr[q]),
      .cmd_len_i        (req_len[q]),
      .cmd_hazard_i     (req_hazard[q]),
      .opq_ready_i      (opq_ready_i[q]),
      .rd_req_o         (rd_req[q]),
      .rd_addr_o        (rd_addr[q]),
      .rd_gnt_i         (rd_gnt[q]),
      .result_written_i (result_written)
    );
  end

  vrf_banks u_vrf (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .rd_req_i         (rd_req),
    .rd_addr_i        (rd_addr),
    .rd_gnt_o         (rd_gnt),
    .wr_req_i         (wr_req),
    .wr_addr_i        (wr_addr),
    .wr_data_i        (wr_data),
    .wr_gnt_o         (wr_gnt),
    .result_written_o (result_written),
    .opq_valid_o      (opq_valid_o),
    .opq_data_o       (opq_data_o)
  );

endmodule

// File: vrf/vrf_banks.sv
////////////////////////////////////////
// Banked VRF with per-bank round-robin
// arbiters and operand read return
////////////////////////////////////////
`timescale 1ns/1ns
`include "lane_config.svh"

module vrf_banks import lane_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Operand reads, one master per queue
  input  logic   [`LANE_NR_QUEUES-1:0]   rd_req_i,
  input  vaddr_t [`LANE_NR_QUEUES-1:0]   rd_addr_i,
  output logic   [`LANE_NR_QUEUES-1:0]   rd_gnt_o,
  // Result write port
  input  logic                           wr_req_i,
  input  vaddr_t                         wr_addr_i,
  input  elem_t                          wr_data_i,
  output logic                           wr_gnt_o,
  output logic                           result_written_o,
  // Operand queue outputs
  output logic   [`LANE_NR_QUEUES-1:0]   opq_valid_o,
  output elem_t  [`LANE_NR_QUEUES-1:0]   opq_data_o
);

  localparam int unsigned nr_queues  = `LANE_NR_QUEUES;
  localparam int unsigned nr_banks   = `LANE_NR_BANKS;
  localparam int unsigned nr_rows    = `LANE_BANK_ROWS;
  // Queues come first, the write port is the last master
  localparam int unsigned nr_masters = nr_queues + 1;
  localparam int unsigned wr_master  = nr_queues;
  localparam int unsigned ptr_w      = $clog2(nr_masters);

  logic [nr_banks-1:0][nr_masters-1:0] bank_req;
  logic [nr_banks-1:0][nr_masters-1:0] bank_gnt;
  logic [nr_banks-1:0][ptr_w-1:0]      rr_ptr_q, rr_ptr_d;
  row_t [nr_queues-1:0]                rd_row;
  row_t                                wr_row;
  elem_t                               mem_q [nr_banks][nr_rows];

  always_comb begin
    bank_req = '0;
    for (int q = 0; q < nr_queues; q++) begin
      bank_req[rd_addr_i[q][bank_w-1:0]][q] = rd_req_i[q];
      rd_row[q] = rd_addr_i[q][vaddr_w-1:bank_w];
    end
    bank_req[wr_addr_i[bank_w-1:0]][wr_master] = wr_req_i;
  end

  assign wr_row = wr_addr_i[vaddr_w-1:bank_w];

  // First requester at or after the pointer wins, pointer moves past it
  always_comb begin
    int unsigned idx;
    logic        found;
    bank_gnt = '0;
    rr_ptr_d = rr_ptr_q;
    for (int b = 0; b < nr_banks; b++) begin
      found = 1'b0;
      for (int i = 0; i < nr_masters; i++) begin
        idx = (int'(rr_ptr_q[b]) + i) % nr_masters;
        if (!found && bank_req[b][idx]) begin
          found          = 1'b1;
          bank_gnt[b][idx] = 1'b1;
          rr_ptr_d[b]    = ptr_w'((idx + 1) % nr_masters);
        end
      end
    end
  end

  // Each master targets one bank, so OR the grants over the banks
  always_comb begin
    rd_gnt_o = '0;
    wr_gnt_o = 1'b0;
    for (int b = 0; b < nr_banks; b++) begin
      rd_gnt_o = rd_gnt_o | bank_gnt[b][nr_queues-1:0];
      wr_gnt_o = wr_gnt_o | bank_gnt[b][wr_master];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q         <= '0;
      opq_valid_o      <= '0;
      result_written_o <= 1'b0;
    end else begin
      rr_ptr_q         <= rr_ptr_d;
      opq_valid_o      <= rd_gnt_o;
      result_written_o <= wr_gnt_o;
    end
  end

  // A bank serves a single master per cycle, so reads never see a same-cycle write
  always_ff @(posedge clk_i) begin
    if (wr_gnt_o) begin
      mem_q[wr_addr_i[bank_w-1:0]][wr_row] <= wr_data_i;
    end
    for (int q = 0; q < nr_queues; q++) begin
      if (rd_gnt_o[q]) begin
        opq_data_o[q] <= mem_q[rd_addr_i[q][bank_w-1:0]][rd_row[q]];
      end
    end
  end

  for (genvar b = 0; b < nr_banks; b++) begin : gen_bank_chk
    // One winner per bank, and only among the masters asking for it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(bank_gnt[b]) && ((bank_gnt[b] & ~bank_req[b]) == '0));
  end

  for (genvar m = 0; m < nr_masters; m++) begin : gen_master_chk
    logic [nr_banks-1:0] gnt_col;
    for (genvar b = 0; b < nr_banks; b++) begin : gen_col
      assign gnt_col[b] = bank_gnt[b][m];
    end
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_col));
  end

endmodule

// File: operand_requester/operand_requester.sv
////////////////////////////////////////
// Operand requester walking one vector
// operand element by element
////////////////////////////////////////
`timescale 1ns/1ns

module operand_requester import lane_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  // Command from the dispatcher
  input  logic   cmd_valid_i,
  output logic   cmd_ready_o,
  input  vaddr_t cmd_addr_i,
  input  vlen_t  cmd_len_i,
  input  logic   cmd_hazard_i,
  // Operand queue has room
  input  logic   opq_ready_i,
  // VRF read request
  output logic   rd_req_o,
  output vaddr_t rd_addr_o,
  input  logic   rd_gnt_i,
  input  logic   result_written_i
);

  typedef enum logic {
    st_idle,
    st_requesting
  } state_e;

  state_e state_q, state_d;
  vaddr_t addr_q, addr_d;
  vlen_t  len_q, len_d;
  logic   hazard_q, hazard_d;
  logic   stall;

  // A hazardous operand only moves right after a result write
  assign stall = hazard_q & ~result_written_i;

  assign cmd_ready_o = (state_q == st_idle);
  assign rd_req_o    = (state_q == st_requesting) & opq_ready_i & ~stall;
  assign rd_addr_o   = addr_q;

  always_comb begin
    state_d  = state_q;
    addr_d   = addr_q;
    len_d    = len_q;
    hazard_d = hazard_q;
    case (state_q)
      st_idle: begin
        if (cmd_valid_i) begin
          addr_d   = cmd_addr_i;
          len_d    = cmd_len_i;
          hazard_d = cmd_hazard_i;
          // Nothing to fetch for an empty operand
          if (cmd_len_i != '0) begin
            state_d = st_requesting;
          end
        end
      end
      st_requesting: begin
        // Next element sits in the next bank
        if (rd_gnt_i) begin
          addr_d = addr_q + vaddr_t'(1);
          len_d  = len_q - vlen_t'(1);
          if (len_q == vlen_t'(1)) begin
            state_d = st_idle;
          end
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= st_idle;
      addr_q   <= '0;
      len_q    <= '0;
      hazard_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      addr_q   <= addr_d;
      len_q    <= len_d;
      hazard_q <= hazard_d;
    end
  end

  // The bank grants only a pending request, and never toward a full queue
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_gnt_i |-> rd_req_o && opq_ready_i);

endmodule

// File: design/lane_cmd_dispatch.sv
////////////////////////////////////////
// Wishbone command dispatcher with
// operand requests, writes and status
////////////////////////////////////////
`timescale 1ns/1ns
`include "lane_config.svh"

module lane_cmd_dispatch import lane_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Wishbone classic slave
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  logic                           wb_adr_i,
  input  lane_cmd_u                      wb_dat_i,
  output logic [31:0]                    wb_dat_o,
  output logic                           wb_ack_o,
  // Commands toward the operand requesters
  output logic   [`LANE_NR_QUEUES-1:0]   req_valid_o,
  input  logic   [`LANE_NR_QUEUES-1:0]   req_ready_i,
  output vaddr_t [`LANE_NR_QUEUES-1:0]   req_addr_o,
  output vlen_t  [`LANE_NR_QUEUES-1:0]   req_len_o,
  output logic   [`LANE_NR_QUEUES-1:0]   req_hazard_o,
  // Result write port
  output logic                           wr_req_o,
  output vaddr_t                         wr_addr_o,
  output elem_t                          wr_data_o,
  input  logic                           wr_gnt_i
);

  localparam int unsigned nr_queues = `LANE_NR_QUEUES;

  logic                 stb_act;
  logic                 cmd_wr;
  logic                 rd_cmd;
  logic                 wr_cmd;
  logic                 bad_queue;
  logic                 ack_d;
  logic [nr_queues-1:0] busy;
  logic [31:0]          rdata_d;
  vaddr_t               start_addr;

  // A transfer is live until its ack has gone out
  assign stb_act = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign cmd_wr  = stb_act & wb_we_i & (wb_adr_i == 1'b0);
  assign rd_cmd  = cmd_wr & ~wb_dat_i.rd.kind;
  assign wr_cmd  = cmd_wr & wb_dat_i.wr.kind;

  // Queue numbers past the last requester are dropped
  assign bad_queue  = (32'(wb_dat_i.rd.queue) >= nr_queues);
  assign start_addr = vaddr_t'(wb_dat_i.rd.vreg) * vaddr_t'(`LANE_VREG_ELEMS)
                      + vaddr_t'(wb_dat_i.rd.vstart);

  always_comb begin
    for (int q = 0; q < nr_queues; q++) begin
      req_valid_o[q]  = rd_cmd & (32'(wb_dat_i.rd.queue) == q);
      req_addr_o[q]   = start_addr;
      req_len_o[q]    = wb_dat_i.rd.vl;
      req_hazard_o[q] = wb_dat_i.rd.hazard;
    end
  end

  assign wr_req_o  = wr_cmd;
  assign wr_addr_o = wb_dat_i.wr.addr;
  assign wr_data_o = wb_dat_i.wr.data;

  // Commands wait for their target, so the host sees the back-pressure
  always_comb begin
    if (rd_cmd) begin
      ack_d = bad_queue | (|(req_valid_o & req_ready_i));
    end else if (wr_cmd) begin
      ack_d = wr_gnt_i;
    end else begin
      ack_d = stb_act;
    end
  end

  // A requester is busy whenever it cannot take a command
  assign busy    = ~req_ready_i;
  assign rdata_d = (stb_act & ~wb_we_i & wb_adr_i) ? 32'(busy) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= ack_d;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_dat_o <= rdata_d;
  end

  // Every ack answers a strobe seen in the cycle before
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i));

endmodule

// File: common/lane_pkg.sv
////////////////////////////////////////
// Lane types: elements, VRF addresses
// and the two views of a command word
////////////////////////////////////////
`include "lane_config.svh"

package lane_pkg;

  localparam int unsigned bank_w  = $clog2(`LANE_NR_BANKS);
  localparam int unsigned row_w   = $clog2(`LANE_BANK_ROWS);
  localparam int unsigned vaddr_w = bank_w + row_w;

  typedef logic [`LANE_ELEM_W-1:0] elem_t;
  // Flat element address with the bank in the low bits
  typedef logic [vaddr_w-1:0] vaddr_t;
  typedef logic [row_w-1:0] row_t;
  typedef logic [3:0] vlen_t;

  // Operand request, kind bit clear
  typedef struct packed {
    logic        kind;
    logic [1:0]  queue;
    logic [4:0]  vreg;
    logic [2:0]  vstart;
    vlen_t       vl;
    logic        hazard;
    logic [15:0] pad;
  } rd_cmd_t;

  // Result write, kind bit set
  typedef struct packed {
    logic       kind;
    vaddr_t     addr;
    elem_t      data;
    logic [6:0] pad;
  } wr_cmd_t;

  typedef union packed {
    rd_cmd_t rd;
    wr_cmd_t wr;
  } lane_cmd_u;

endpackage

// File: common/lane_config.svh
////////////////////////////////////////
// Lane sizing macros: queues, banks,
// bank depth and element width
////////////////////////////////////////
`ifndef LANE_CONFIG_SVH
`define LANE_CONFIG_SVH

// Operand queues, one requester each
`define LANE_NR_QUEUES 3

// VRF banks, selected by the low address bits
`define LANE_NR_BANKS 4

// Rows in each bank
`define LANE_BANK_ROWS 64

// Width of one vector element
`define LANE_ELEM_W 16

// Elements held by one vector register
`define LANE_VREG_ELEMS 8

`endif
